// File: sim/sddac_patterns.txt
// One hex word per line, positions fixed: 0 ctrl word (disabled, divider 24), 1 STATUS after reset
// 2,3 samples A and B, 4 STATUS with one held, 5-8 underrun ticks and counts, 9,10 STATUS, 11 sample C
00000030
00000000
40001000
c000f000
00000001
00000004
00000004
00000100
000000ff
0000ff01
0000ff00
2000e000
// Number of stereo pairs, then the pairs, left in bits 31:16
0000000a
7fff8001
80017fff
00000000
3fffc000
c0003fff
12340f0f
edccf0f1
55552aaa
aaabd556
01000100

// File: vlog.f
+incdir+source
source/sddac_pkg.sv
source/sddac_regs.sv
source/sddac_pacer.sv
source/sddac_alu48.sv
source/sddac_dac_2ord.sv
source/sddac_top.sv
sim/sddac_sva.sv
sim/sddac_tb.sv

// File: Makefile
# Verilator build and run for the sigma-delta audio output block

SRCS := $(wildcard source/*.sv source/*.svh sim/*.sv)

all: run

obj_dir/Vsddac_tb: vlog.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module sddac_tb -Mdir obj_dir

run: obj_dir/Vsddac_tb sim/sddac_patterns.txt
	./obj_dir/Vsddac_tb | tee sim.log
	grep -q "^PASS: all tests$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

// File: sim/sddac_tb.sv
`timescale 1ns/1ps
`include "sddac_macros.svh"

module sddac_tb;
    import sddac_pkg::*;

    localparam int PAT_WORDS  = 23;
    localparam int WAIT_LIMIT = 2000;

    // Dithered feedback table, one entry per stereo sample
    localparam logic [17:0] DELTA_TAB [16] = '{
        18'h18000, 18'h189c7, 18'h19216, 18'h197a4,
        18'h19998, 18'h197a4, 18'h19216, 18'h189c7,
        18'h18000, 18'h17639, 18'h16dea, 18'h1685c,
        18'h16668, 18'h1685c, 18'h16dea, 18'h17639
    };

    logic        clk;
    logic        reset;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [1:0]  wb_adr;
    bus_word_u   wb_dat_i;
    logic [31:0] wb_dat_o;
    logic        wb_ack;
    logic        dout_l;
    logic        dout_r;

    logic [31:0] pat [0:PAT_WORDS-1];

    // Reference model state
    logic signed [47:0] m_i1l;
    logic signed [47:0] m_i2l;
    logic signed [47:0] m_i1r;
    logic               m_add_l;
    logic               m_add_r;
    logic [3:0]         m_idx;
    bus_word_u          m_last;
    bus_word_u          m_held;
    logic               m_full;
    logic [1:0]         exp_bits;

    int   check_wait;
    int   tick_count;
    int   checks;
    int   errors;
    int   test_errors;
    int   tests;
    logic timed_out;

    sddac_top UUT (
        .clk      (clk),
        .reset    (reset),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_i (wb_dat_i),
        .wb_dat_o (wb_dat_o),
        .wb_ack   (wb_ack),
        .dout_l   (dout_l),
        .dout_r   (dout_r)
    );

    always #4 clk = ~clk;

    // ------------------------------
    // Checks
    // ------------------------------
    task automatic report_error(input string what);
        errors++;
        test_errors++;
        $display("Error at %0t ns: %s", $time, what);
    endtask

    task automatic check_word(input string name, input bus_word_u got, input bus_word_u exp);
        if (timed_out) return;
        checks++;
        if (got !== exp) begin
            errors++;
            test_errors++;
            $display("Mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (timed_out) return;
        checks++;
        if (got !== exp) begin
            errors++;
            test_errors++;
            $display("Mismatch at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_bits(input logic [1:0] got, input logic [1:0] exp);
        if (timed_out) return;
        checks++;
        if (got !== exp) begin
            errors++;
            test_errors++;
            $display("Mismatch at %0t ns: dout_l,dout_r got %b expected %b", $time, got, exp);
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        if (test_errors == 0) begin
            $display("test %0d %s: ok", tests, name);
        end else begin
            $display("test %0d %s: %0d errors", tests, name, test_errors);
        end
        test_errors = 0;
    endtask

    // ------------------------------
    // Reference model
    // ------------------------------
    // Left is second order, right keeps a single integrator
    task automatic model_sample(input bus_word_u smp);
        logic signed [47:0] d;
        logic signed [47:0] sl;
        logic signed [47:0] sr;
        logic signed [47:0] a;
        d        = {30'd0, DELTA_TAB[m_idx]};
        sl       = $signed(smp.sample.left);
        sr       = $signed(smp.sample.right);
        m_i1l    = m_i1l + sl + (m_add_l ? d : -d);
        a        = m_i1l + m_i2l + (m_add_l ? d : -d);
        m_i2l    = a;
        m_add_l  = a[47];
        m_i1r    = m_i1r + sr + (m_add_r ? d : -d);
        m_add_r  = m_i1r[47];
        exp_bits = {~a[47], ~m_i1r[47]};
        m_idx    = m_idx + 4'd1;
    endtask

    // One clock, then tick bookkeeping and the pending output check
    task automatic step();
        if (timed_out) return;
        @(posedge clk);
        #1;
        if (UUT.sample_in_rdy) begin
            tick_count++;
            if (m_full) begin
                m_last = m_held;
                m_full = 1'b0;
            end
            model_sample(m_last);
            check_wait = 8;
        end else if (check_wait > 0) begin
            check_wait--;
            if (check_wait == 0) begin
                check_bits({dout_l, dout_r}, exp_bits);
            end
        end
    endtask

    task automatic wait_tick();
        int n;
        int start;
        n     = 0;
        start = tick_count;
        while (tick_count == start && n < WAIT_LIMIT && !timed_out) begin
            step();
            n++;
        end
        if (tick_count == start && !timed_out) begin
            report_error("no sample tick from the pacer within the wait limit");
            timed_out = 1'b1;
        end
    endtask

    task automatic wait_check();
        int n;
        n = 0;
        while (check_wait != 0 && n < WAIT_LIMIT && !timed_out) begin
            step();
            n++;
        end
        if (check_wait != 0 && !timed_out) begin
            report_error("output check never came due");
            timed_out = 1'b1;
        end
    endtask

    // ------------------------------
    // Wishbone master
    // ------------------------------
    task automatic bus_cycle(input logic we, input logic [1:0] adr, input bus_word_u data,
                             output bus_word_u rd);
        int n;
        n        = 0;
        rd       = '0;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_i = data;
        step();
        while (!wb_ack && n < WAIT_LIMIT && !timed_out) begin
            step();
            n++;
        end
        if (wb_ack) begin
            rd = wb_dat_o;
            if (we && adr == `SDDAC_ADDR_SAMPLE) begin
                m_held = data;
                m_full = 1'b1;
            end
            // Transfer completes on the edge that sees ack
            step();
        end else if (!timed_out) begin
            report_error($sformatf("bus cycle to address %0d was never acknowledged", adr));
            timed_out = 1'b1;
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic bus_write(input logic [1:0] adr, input bus_word_u data);
        bus_word_u unused;
        bus_cycle(1'b1, adr, data, unused);
    endtask

    task automatic bus_read(input logic [1:0] adr, output bus_word_u data);
        bus_cycle(1'b0, adr, '0, data);
    endtask

    // ------------------------------
    // Test sequence
    // ------------------------------
    initial begin
        bus_word_u   w;
        bus_word_u   rd;
        logic [1:0]  held_bits;
        int          start;
        int          n_pairs;
        int          i;
        clk         = 1'b0;
        reset       = 1'b1;
        wb_cyc      = 1'b0;
        wb_stb      = 1'b0;
        wb_we       = 1'b0;
        wb_adr      = 2'd0;
        wb_dat_i    = '0;
        m_i1l       = '0;
        m_i2l       = '0;
        m_i1r       = '0;
        m_add_l     = 1'b0;
        m_add_r     = 1'b0;
        m_idx       = 4'd0;
        m_last      = '0;
        m_held      = '0;
        m_full      = 1'b0;
        exp_bits    = 2'b00;
        check_wait  = 0;
        tick_count  = 0;
        checks      = 0;
        errors      = 0;
        test_errors = 0;
        tests       = 0;
        timed_out   = 1'b0;
        $readmemh("sim/sddac_patterns.txt", pat);
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;

        // Control register and idle status
        bus_read(`SDDAC_ADDR_STATUS, rd);
        check_word("wb_dat_o status after reset", rd, pat[1]);
        w = pat[0];
        bus_write(`SDDAC_ADDR_CTRL, w);
        bus_read(`SDDAC_ADDR_CTRL, rd);
        check_word("wb_dat_o ctrl readback", rd, w);
        end_test("ctrl write and readback");

        // Back pressure on a full holding register
        bus_write(`SDDAC_ADDR_SAMPLE, pat[2]);
        bus_read(`SDDAC_ADDR_STATUS, rd);
        check_word("wb_dat_o status with sample held", rd, pat[4]);
        w.ctrl.enable = 1'b1;
        bus_write(`SDDAC_ADDR_CTRL, w);
        start = tick_count;
        bus_write(`SDDAC_ADDR_SAMPLE, pat[3]);
        if (!timed_out && tick_count == start) begin
            report_error("second sample write was acknowledged before a tick emptied the register");
        end
        bus_read(`SDDAC_ADDR_STATUS, rd);
        check_word("wb_dat_o status after stalled write", rd, pat[4]);
        end_test("sample write back pressure");

        // One new pair per tick, written right after each output check
        n_pairs = pat[12];
        for (i = 0; i < n_pairs && 13 + i < PAT_WORDS; i++) begin
            wait_tick();
            wait_check();
            bus_write(`SDDAC_ADDR_SAMPLE, pat[13 + i]);
        end
        wait_tick();
        wait_check();
        end_test("modulator output against model");

        // Host stops writing
        repeat (pat[5]) wait_tick();
        wait_check();
        bus_read(`SDDAC_ADDR_STATUS, rd);
        check_count("underrun_cnt", rd[15:8], pat[6][7:0]);
        repeat (pat[7]) wait_tick();
        wait_check();
        bus_read(`SDDAC_ADDR_STATUS, rd);
        check_count("underrun_cnt", rd[15:8], pat[8][7:0]);
        end_test("underrun count and repeated sample");

        // Disabled outputs hold, held sample survives
        w.ctrl.enable = 1'b0;
        bus_write(`SDDAC_ADDR_CTRL, w);
        held_bits = {dout_l, dout_r};
        start     = tick_count;
        bus_write(`SDDAC_ADDR_SAMPLE, pat[11]);
        for (i = 0; i < 3 * (w.ctrl.rate_div + 1); i++) begin
            step();
            check_bits({dout_l, dout_r}, held_bits);
        end
        if (!timed_out && tick_count != start) begin
            report_error("pacer issued a sample tick while disabled");
        end
        bus_read(`SDDAC_ADDR_STATUS, rd);
        check_word("wb_dat_o status while disabled", rd, pat[9]);
        w.ctrl.enable = 1'b1;
        bus_write(`SDDAC_ADDR_CTRL, w);
        wait_tick();
        wait_check();
        bus_read(`SDDAC_ADDR_STATUS, rd);
        check_word("wb_dat_o status after re-enable", rd, pat[10]);
        end_test("disable hold and re-enable");

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: sim/sddac_sva.sv
`timescale 1ns/1ps

module sddac_sva (
    input logic       clk,
    input logic       reset,
    input logic       wb_cyc,
    input logic       wb_stb,
    input logic       wb_ack,
    input logic       sample_in_rdy,
    input logic [3:0] pc,
    input logic       dout_l
);

    // Earlier sample_in_rdy values, bit 0 is one cycle back
    logic [5:0] rdy_hist;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rdy_hist <= '0;
        end else begin
            rdy_hist <= {rdy_hist[4:0], sample_in_rdy};
        end
    end

    // ------------------------------
    // Bus handshake
    // ------------------------------
    ack_in_cycle: assert property (@(posedge clk) disable iff (reset)
        wb_ack |-> (wb_cyc && wb_stb))
        else $error("wb_ack outside an open bus cycle");

    ack_single: assert property (@(posedge clk) disable iff (reset)
        wb_ack |=> !wb_ack)
        else $error("wb_ack high on two cycles in a row");

    // ------------------------------
    // Modulator program
    // ------------------------------
    // New sample only at the wait step
    rdy_idle_only: assert property (@(posedge clk) disable iff (reset)
        sample_in_rdy |-> (pc == 4'h0))
        else $error("sample_in_rdy while the modulator program is running");

    dout_l_timing: assert property (@(posedge clk) disable iff (reset)
        $changed(dout_l) |-> rdy_hist[5])
        else $error("dout_l changed outside its program step");

endmodule

bind sddac_top sddac_sva u_sva (
    .clk           (clk),
    .reset         (reset),
    .wb_cyc        (wb_cyc),
    .wb_stb        (wb_stb),
    .wb_ack        (wb_ack),
    .sample_in_rdy (sample_in_rdy),
    .pc            (u_dac.pc),
    .dout_l        (dout_l)
);

// File: source/sddac_top.sv
`timescale 1ns/1ps
`include "sddac_macros.svh"

module sddac_top (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 wb_cyc,
    input  logic                 wb_stb,
    input  logic                 wb_we,
    input  logic [1:0]           wb_adr,
    input  sddac_pkg::bus_word_u wb_dat_i,
    output logic [31:0]          wb_dat_o,
    output logic                 wb_ack,
    output logic                 dout_l,
    output logic                 dout_r
);
    import sddac_pkg::*;

    // Bus slave to pacer
    logic                              enable;
    logic [`SDDAC_DIV_W-1:0]           rate_div;
    logic signed [`SDDAC_SAMPLE_W-1:0] hold_l;
    logic signed [`SDDAC_SAMPLE_W-1:0] hold_r;
    logic                              hold_full;
    logic                              take;
    logic [7:0]                        underrun_cnt;

    // Pacer to modulator
    logic signed [`SDDAC_SAMPLE_W-1:0] sample_in_l;
    logic signed [`SDDAC_SAMPLE_W-1:0] sample_in_r;
    logic                              sample_in_rdy;

    // Shared adder
    alu_op_t                           opmode;
    logic signed [`SDDAC_ACC_W-1:0]    dab;
    logic signed [`SDDAC_ACC_W-1:0]    cin;
    logic signed [`SDDAC_ACC_W-1:0]    p;

    sddac_regs u_regs (
        .clk          (clk),
        .reset        (reset),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .wb_dat_i     (wb_dat_i),
        .wb_dat_o     (wb_dat_o),
        .wb_ack       (wb_ack),
        .take         (take),
        .underrun_cnt (underrun_cnt),
        .enable       (enable),
        .rate_div     (rate_div),
        .hold_l       (hold_l),
        .hold_r       (hold_r),
        .hold_full    (hold_full)
    );

    sddac_pacer u_pacer (
        .clk           (clk),
        .reset         (reset),
        .enable        (enable),
        .rate_div      (rate_div),
        .hold_l        (hold_l),
        .hold_r        (hold_r),
        .hold_full     (hold_full),
        .take          (take),
        .sample_in_l   (sample_in_l),
        .sample_in_r   (sample_in_r),
        .sample_in_rdy (sample_in_rdy),
        .underrun_cnt  (underrun_cnt)
    );

    sddac_dac_2ord u_dac (
        .clk           (clk),
        .reset         (reset),
        .sample_in_l   (sample_in_l),
        .sample_in_r   (sample_in_r),
        .sample_in_rdy (sample_in_rdy),
        .opmode        (opmode),
        .dab           (dab),
        .cin           (cin),
        .p             (p),
        .dout_l        (dout_l),
        .dout_r        (dout_r)
    );

    sddac_alu48 u_alu (
        .clk    (clk),
        .reset  (reset),
        .opmode (opmode),
        .dab    (dab),
        .cin    (cin),
        .p      (p)
    );

endmodule

// File: source/sddac_dac_2ord.sv
`timescale 1ns/1ps
`include "sddac_macros.svh"

module sddac_dac_2ord (
    input  logic                              clk,
    input  logic                              reset,
    input  logic signed [`SDDAC_SAMPLE_W-1:0] sample_in_l,
    input  logic signed [`SDDAC_SAMPLE_W-1:0] sample_in_r,
    input  logic                              sample_in_rdy,
    output sddac_pkg::alu_op_t                opmode,
    output logic signed [`SDDAC_ACC_W-1:0]    dab,
    output logic signed [`SDDAC_ACC_W-1:0]    cin,
    input  logic signed [`SDDAC_ACC_W-1:0]    p,
    output logic                              dout_l,
    output logic                              dout_r
);
    import sddac_pkg::*;

    localparam int EXT_W = `SDDAC_ACC_W - `SDDAC_SAMPLE_W;

    // Task bits of the decoded program word
    localparam int WAIT_IN     = 0;
    localparam int JP_0        = 1;
    localparam int ADD_SL_I1L  = 2;
    localparam int ADD_SR_I1R  = 3;
    localparam int ADD_DL      = 4;
    localparam int ADD_DR      = 5;
    localparam int ADD_I2L     = 6;
    localparam int MOV_I1L_ACC = 7;
    localparam int MOV_I1R_ACC = 8;
    localparam int MOV_I2L_ACC = 9;
    localparam int MOV_DL_SGN  = 10;
    localparam int MOV_DR_SGN  = 11;
    localparam int MOV_OUTL    = 12;
    localparam int MOV_OUTR    = 13;
    localparam int INC_DELTA   = 14;

    logic [14:0]                       tasks;
    logic [3:0]                        pc;
    logic [3:0]                        delta_cnt;
    logic signed [`SDDAC_SAMPLE_W-1:0] delta;
    logic signed [`SDDAC_SAMPLE_W-1:0] smp_l;
    logic signed [`SDDAC_SAMPLE_W-1:0] smp_r;
    logic signed [`SDDAC_ACC_W-1:0]    integ1_l;
    logic signed [`SDDAC_ACC_W-1:0]    integ1_r;
    logic signed [`SDDAC_ACC_W-1:0]    integ2_l;
    logic                              delta_add_l;
    logic                              delta_add_r;

    function automatic alu_op_t make_op(input logic [1:0] zsel, input logic sub);
        alu_op_t op;
        op                               = '0;
        op[`SDDAC_OP_XSEL_BIT]           = 1'b1;
        op[`SDDAC_OP_ZSEL_LSB +: 2]      = zsel;
        op[`SDDAC_OP_SUB_BIT]            = sub;
        return op;
    endfunction

    // ------------------------------
    // Program
    // ------------------------------
    always_comb begin
        tasks = '0;
        case (pc)
            4'h0: tasks[WAIT_IN] = 1'b1;
            // Left channel
            4'h1: tasks[ADD_SL_I1L] = 1'b1;
            4'h2: tasks[ADD_DL] = 1'b1;
            4'h3: begin
                tasks[MOV_I1L_ACC] = 1'b1;
                tasks[ADD_I2L]     = 1'b1;
            end
            4'h4: tasks[ADD_DL] = 1'b1;
            4'h5: begin
                tasks[MOV_DL_SGN]  = 1'b1;
                tasks[MOV_I2L_ACC] = 1'b1;
                tasks[MOV_OUTL]    = 1'b1;
                // right channel starts here
                tasks[ADD_SR_I1R]  = 1'b1;
            end
            4'h6: tasks[ADD_DR] = 1'b1;
            4'h7: begin
                tasks[MOV_DR_SGN]  = 1'b1;
                tasks[MOV_I1R_ACC] = 1'b1;
                tasks[MOV_OUTR]    = 1'b1;
                tasks[INC_DELTA]   = 1'b1;
                tasks[JP_0]        = 1'b1;
            end
            default: tasks[JP_0] = 1'b1;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= 4'h0;
        end else if (tasks[JP_0]) begin
            pc <= 4'h0;
        end else if (!tasks[WAIT_IN] || sample_in_rdy) begin
            pc <= pc + 4'h1;
        end
    end

    // Sample only taken at the wait step
    always_ff @(posedge clk) begin
        if (tasks[WAIT_IN] && sample_in_rdy) begin
            smp_l <= sample_in_l;
            smp_r <= sample_in_r;
        end
    end

    // ------------------------------
    // Dithered delta table
    // ------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            delta_cnt <= 4'h0;
        end else if (tasks[INC_DELTA]) begin
            delta_cnt <= delta_cnt + 4'h1;
        end
    end

    always_comb begin
        case (delta_cnt)
            4'h0, 4'h8: delta = 18'h18000;
            4'h1, 4'h7: delta = 18'h189c7;
            4'h2, 4'h6: delta = 18'h19216;
            4'h3, 4'h5: delta = 18'h197a4;
            4'h4:       delta = 18'h19998;
            4'h9, 4'hf: delta = 18'h17639;
            4'ha, 4'he: delta = 18'h16dea;
            4'hb, 4'hd: delta = 18'h1685c;
            default:    delta = 18'h16668;
        endcase
    end

    // ------------------------------
    // Adder steering
    // ------------------------------
    always_comb begin
        opmode = '0;
        dab    = '0;
        cin    = '0;
        if (tasks[ADD_SL_I1L]) begin
            opmode = make_op(`SDDAC_ZSEL_CIN, 1'b0);
            dab    = integ1_l;
            cin    = {{EXT_W{smp_l[`SDDAC_SAMPLE_W-1]}}, smp_l};
        end else if (tasks[ADD_SR_I1R]) begin
            opmode = make_op(`SDDAC_ZSEL_CIN, 1'b0);
            dab    = integ1_r;
            cin    = {{EXT_W{smp_r[`SDDAC_SAMPLE_W-1]}}, smp_r};
        end else if (tasks[ADD_DL]) begin
            opmode = make_op(`SDDAC_ZSEL_P, !delta_add_l);
            dab    = {{EXT_W{1'b0}}, delta};
        end else if (tasks[ADD_DR]) begin
            opmode = make_op(`SDDAC_ZSEL_P, !delta_add_r);
            dab    = {{EXT_W{1'b0}}, delta};
        end else if (tasks[ADD_I2L]) begin
            opmode = make_op(`SDDAC_ZSEL_P, 1'b0);
            dab    = integ2_l;
        end
    end

    // ------------------------------
    // State updates from p
    // ------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            integ1_l    <= '0;
            integ1_r    <= '0;
            integ2_l    <= '0;
            delta_add_l <= 1'b0;
            delta_add_r <= 1'b0;
            dout_l      <= 1'b0;
            dout_r      <= 1'b0;
        end else begin
            if (tasks[MOV_I1L_ACC]) begin
                integ1_l <= p;
            end
            if (tasks[MOV_I1R_ACC]) begin
                integ1_r <= p;
            end
            if (tasks[MOV_I2L_ACC]) begin
                integ2_l <= p;
            end
            // Negative sum means add delta next time
            if (tasks[MOV_DL_SGN]) begin
                delta_add_l <= p[`SDDAC_ACC_W-1];
            end
            if (tasks[MOV_DR_SGN]) begin
                delta_add_r <= p[`SDDAC_ACC_W-1];
            end
            if (tasks[MOV_OUTL]) begin
                dout_l <= ~p[`SDDAC_ACC_W-1];
            end
            if (tasks[MOV_OUTR]) begin
                dout_r <= ~p[`SDDAC_ACC_W-1];
            end
        end
    end

endmodule

// File: source/sddac_alu48.sv
`timescale 1ns/1ps
`include "sddac_macros.svh"

module sddac_alu48 (
    input  logic                           clk,
    input  logic                           reset,
    input  sddac_pkg::alu_op_t             opmode,
    input  logic signed [`SDDAC_ACC_W-1:0] dab,
    input  logic signed [`SDDAC_ACC_W-1:0] cin,
    output logic signed [`SDDAC_ACC_W-1:0] p
);

    logic signed [`SDDAC_ACC_W-1:0] x_mux;
    logic signed [`SDDAC_ACC_W-1:0] z_mux;
    logic [1:0]                     zsel;

    assign zsel  = opmode[`SDDAC_OP_ZSEL_LSB +: 2];
    assign x_mux = opmode[`SDDAC_OP_XSEL_BIT] ? dab : '0;

    // Z source
    always_comb begin
        case (zsel)
            `SDDAC_ZSEL_P:   z_mux = p;
            `SDDAC_ZSEL_CIN: z_mux = cin;
            default:         z_mux = '0;
        endcase
    end

    // Post adder, result one cycle after its opmode
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            p <= '0;
        end else if (opmode[`SDDAC_OP_SUB_BIT]) begin
            p <= z_mux - x_mux;
        end else begin
            p <= z_mux + x_mux;
        end
    end

endmodule

// File: source/sddac_pacer.sv
`timescale 1ns/1ps
`include "sddac_macros.svh"

module sddac_pacer (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              enable,
    input  logic [`SDDAC_DIV_W-1:0]           rate_div,
    input  logic signed [`SDDAC_SAMPLE_W-1:0] hold_l,
    input  logic signed [`SDDAC_SAMPLE_W-1:0] hold_r,
    input  logic                              hold_full,
    output logic                              take,
    output logic signed [`SDDAC_SAMPLE_W-1:0] sample_in_l,
    output logic signed [`SDDAC_SAMPLE_W-1:0] sample_in_r,
    output logic                              sample_in_rdy,
    output logic [7:0]                        underrun_cnt
);

    logic [`SDDAC_DIV_W-1:0] div_cnt;
    logic                    tick;

    // One tick every rate_div+1 cycles
    assign tick = enable && (div_cnt == rate_div);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            div_cnt <= '0;
        end else if (!enable || tick) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sample_in_rdy <= 1'b0;
            take          <= 1'b0;
            sample_in_l   <= '0;
            sample_in_r   <= '0;
            underrun_cnt  <= '0;
        end else begin
            sample_in_rdy <= tick;
            take          <= tick && hold_full;
            if (tick && hold_full) begin
                sample_in_l <= hold_l;
                sample_in_r <= hold_r;
            end
            // Host was late, previous sample goes out again
            if (tick && !hold_full && (underrun_cnt != 8'hff)) begin
                underrun_cnt <= underrun_cnt + 8'd1;
            end
        end
    end

endmodule

// File: source/sddac_regs.sv
`timescale 1ns/1ps
`include "sddac_macros.svh"

module sddac_regs (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              wb_cyc,
    input  logic                              wb_stb,
    input  logic                              wb_we,
    input  logic [1:0]                        wb_adr,
    input  sddac_pkg::bus_word_u              wb_dat_i,
    output logic [31:0]                       wb_dat_o,
    output logic                              wb_ack,
    input  logic                              take,
    input  logic [7:0]                        underrun_cnt,
    output logic                              enable,
    output logic [`SDDAC_DIV_W-1:0]           rate_div,
    output logic signed [`SDDAC_SAMPLE_W-1:0] hold_l,
    output logic signed [`SDDAC_SAMPLE_W-1:0] hold_r,
    output logic                              hold_full
);
    import sddac_pkg::*;

    localparam int EXT_W = `SDDAC_SAMPLE_W - `SDDAC_PCM_W;

    logic      access;
    logic      sample_wr;
    logic      accept;
    bus_word_u rd_word;

    // Open request not yet acknowledged
    assign access    = wb_cyc && wb_stb && !wb_ack;
    assign sample_wr = wb_we && (wb_adr == `SDDAC_ADDR_SAMPLE);

    // Sample writes stall while the holding register is occupied
    assign accept = access && !(sample_wr && hold_full);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= accept;
        end
    end

    // ------------------------------
    // Control register
    // ------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            enable   <= 1'b0;
            rate_div <= '0;
        end else if (accept && wb_we && (wb_adr == `SDDAC_ADDR_CTRL)) begin
            enable   <= wb_dat_i.ctrl.enable;
            rate_div <= wb_dat_i.ctrl.rate_div;
        end
    end

    // ------------------------------
    // Sample holding register
    // ------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            hold_full <= 1'b0;
        end else if (accept && sample_wr) begin
            hold_full <= 1'b1;
        end else if (take) begin
            hold_full <= 1'b0;
        end
    end

    // Sign extend to modulator width on the way in
    always_ff @(posedge clk) begin
        if (accept && sample_wr) begin
            hold_l <= {{EXT_W{wb_dat_i.sample.left[`SDDAC_PCM_W-1]}}, wb_dat_i.sample.left};
            hold_r <= {{EXT_W{wb_dat_i.sample.right[`SDDAC_PCM_W-1]}}, wb_dat_i.sample.right};
        end
    end

    // Read mux
    always_comb begin
        rd_word = '0;
        case (wb_adr)
            `SDDAC_ADDR_CTRL: begin
                rd_word.ctrl.enable   = enable;
                rd_word.ctrl.rate_div = rate_div;
            end
            `SDDAC_ADDR_SAMPLE: begin
                rd_word.sample.left  = hold_l[`SDDAC_PCM_W-1:0];
                rd_word.sample.right = hold_r[`SDDAC_PCM_W-1:0];
            end
            `SDDAC_ADDR_STATUS: begin
                rd_word[0]    = hold_full;
                rd_word[15:8] = underrun_cnt;
            end
            default: rd_word = '0;
        endcase
    end

    assign wb_dat_o = rd_word;

endmodule

// File: source/sddac_pkg.sv
`include "sddac_macros.svh"

package sddac_pkg;

    // Control register view
    typedef struct packed {
        logic [30-`SDDAC_DIV_W:0]  unused;
        logic [`SDDAC_DIV_W-1:0]   rate_div;
        logic                      enable;
    } ctrl_word_t;

    // Stereo sample view, left in the upper half
    typedef struct packed {
        logic signed [`SDDAC_PCM_W-1:0] left;
        logic signed [`SDDAC_PCM_W-1:0] right;
    } sample_word_t;

    // One bus word, decoded by address
    typedef union packed {
        ctrl_word_t   ctrl;
        sample_word_t sample;
    } bus_word_u;

    // Adder opmode, field positions in the macro header
    typedef logic [7:0] alu_op_t;

endpackage

// File: source/sddac_macros.svh
`ifndef SDDAC_MACROS_SVH
`define SDDAC_MACROS_SVH

// ------------------------------
// Datapath widths
// ------------------------------
`define SDDAC_SAMPLE_W      18
`define SDDAC_ACC_W         48
`define SDDAC_PCM_W         16
`define SDDAC_DIV_W         12

// Word addresses on the bus
`define SDDAC_ADDR_CTRL     2'd0
`define SDDAC_ADDR_SAMPLE   2'd1
`define SDDAC_ADDR_STATUS   2'd2

// ------------------------------
// Adder opmode byte
// ------------------------------
// X operand is dab when set, zero otherwise
`define SDDAC_OP_XSEL_BIT   0
// Two bit Z source field
`define SDDAC_OP_ZSEL_LSB   1
// Subtract X from Z when set
`define SDDAC_OP_SUB_BIT    7

// Z source codes, all zero byte keeps p
`define SDDAC_ZSEL_P        2'd0
`define SDDAC_ZSEL_CIN      2'd1
`define SDDAC_ZSEL_ZERO     2'd2

`endif
